//--- verilog/revo_pkg.sv
`default_nettype none

package revo_pkg;

	// --------------------------------------------------
	// line protocol widths
	// --------------------------------------------------
	localparam int history_width = 16;
	// size of the newer half of the history
	localparam int max_duration = 8;
	localparam int word_width = 8;
	localparam int bit_index_width = $clog2(word_width);

	// bit 0 is the newest revo sample
	typedef logic [history_width-1:0] history_t;
	// one half of the history
	typedef logic [max_duration-1:0] window_t;
	typedef logic [word_width-1:0] line_word_t;
	// position inside a line word
	typedef logic [bit_index_width-1:0] bit_index_t;

	// --------------------------------------------------
	// line words, sent msb first
	// --------------------------------------------------
	localparam line_word_t word_null = 8'b11000000;
	localparam line_word_t word_trg = 8'b00111111;

	// trigger decision steps, one per clock
	typedef enum logic [1:0] {
		capture,
		evaluate,
		decide,
		hold
	} trg_state_t;

endpackage

`default_nettype wire

//--- verilog/revo_input_sync.sv
`timescale 1ns/1ps
`default_nettype none

module revo_input_sync (
	input wire logic clock2,
	input wire logic reset,
	input wire logic revo_in,
	output revo_pkg::history_t history
);
	import revo_pkg::*;

	// two flop synchronizer stages
	logic sync_meta;
	logic sync_stable;

	// --------------------------------------------------
	// synchronizer
	// --------------------------------------------------
	always_ff @(posedge clock2) begin
		if (reset) begin
			sync_meta <= 1'b0;
			sync_stable <= 1'b0;
		end else begin
			sync_meta <= revo_in;
			sync_stable <= sync_meta;
		end
	end

	// --------------------------------------------------
	// sample history
	// --------------------------------------------------
	// newest sample enters at bit 0, oldest falls off the top
	always_ff @(posedge clock2) begin
		if (reset) begin
			history <= '0;
		end else begin
			history <= {history[history_width-2:0], sync_stable};
		end
	end

	// history feeds the trigger decision, so no x may reach it
	history_known: assert property (
		@(posedge clock2) disable iff (reset)
		!$isunknown(history)
	);

endmodule

`default_nettype wire

//--- verilog/phase_timer.sv
`timescale 1ns/1ps
`default_nettype none

module phase_timer (
	input wire logic clock2,
	input wire logic reset,
	output revo_pkg::bit_index_t bit_index,
	output logic eval_tick
);
	import revo_pkg::*;

	bit_index_t count;

	// --------------------------------------------------
	// word bit counter
	// --------------------------------------------------
	// wraps from 7 to 0 on its own
	always_ff @(posedge clock2) begin
		if (reset) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	assign bit_index = count;

	// last cycle of each half word, at count 3 and 7
	assign eval_tick = (count[1:0] == 2'b11);

	// the trigger rounds rely on a strict four cycle pace
	eval_tick_period: assert property (
		@(posedge clock2) disable iff (reset)
		eval_tick |=> !eval_tick [*3] ##1 eval_tick
	);

endmodule

`default_nettype wire

//--- verilog/revo_trigger_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module revo_trigger_fsm (
	input wire logic clock2,
	input wire logic reset,
	input wire revo_pkg::history_t history,
	input wire logic eval_tick,
	output logic trg
);
	import revo_pkg::*;

	trg_state_t state;

	// history frozen for one round
	history_t captured;
	window_t upper;
	window_t lower;

	// pulse window conditions
	logic upper_zero;
	logic lower_nonzero;
	logic newest_zero;

	// result of the last finished round
	logic accept;

	// --------------------------------------------------
	// history split
	// --------------------------------------------------
	assign upper = captured[history_width-1:max_duration];
	assign lower = captured[max_duration-1:0];

	// --------------------------------------------------
	// decision state machine
	// --------------------------------------------------
	always_ff @(posedge clock2) begin
		if (reset) begin
			state <= hold;
			accept <= 1'b0;
			trg <= 1'b0;
		end else begin
			case (state)
				capture: begin
					state <= evaluate;
				end
				evaluate: begin
					state <= decide;
				end
				decide: begin
					// all three must hold, else the pulse is too long or still open
					accept <= upper_zero & lower_nonzero & newest_zero;
					state <= hold;
				end
				default: begin
					if (eval_tick) begin
						// new trg level shows in the capture cycle
						trg <= accept;
						state <= capture;
					end
				end
			endcase
		end
	end

	// payload of the round, only read in the steps after it is written
	always_ff @(posedge clock2) begin
		if (state == capture) begin
			captured <= history;
		end
		if (state == evaluate) begin
			upper_zero <= (upper == '0);
			lower_nonzero <= (lower != '0);
			newest_zero <= ~captured[0];
		end
	end

	// trg may only move at the start of a round
	trg_change_on_capture: assert property (
		@(posedge clock2) disable iff (reset)
		$changed(trg) |-> (state == capture)
	);

endmodule

`default_nettype wire

//--- verilog/revo_word_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module revo_word_serializer (
	input wire logic clock2,
	input wire logic reset,
	input wire revo_pkg::bit_index_t bit_index,
	input wire logic trg,
	output logic data,
	output logic frame
);
	import revo_pkg::*;

	// word picked from the trigger level
	line_word_t load_word;
	// bits still to send after the msb
	line_word_t shift_word;
	// low for the first cycle out of reset
	logic armed;
	logic word_start;

	assign word_start = (bit_index == '0);
	assign load_word = trg ? word_trg : word_null;

	// --------------------------------------------------
	// output enable
	// --------------------------------------------------
	always_ff @(posedge clock2) begin
		if (reset) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	// --------------------------------------------------
	// shift register
	// --------------------------------------------------
	// msb goes out directly at bit 0, the rest is kept here
	always_ff @(posedge clock2) begin
		if (word_start) begin
			shift_word <= load_word << 1;
		end else begin
			shift_word <= shift_word << 1;
		end
	end

	// --------------------------------------------------
	// serial outputs
	// --------------------------------------------------
	always_comb begin
		if (!armed) begin
			data = 1'b0;
		end else if (word_start) begin
			data = load_word[word_width-1];
		end else begin
			data = shift_word[word_width-1];
		end
	end

	assign frame = armed & word_start;

	// frame marks bit 0 and repeats once per word
	frame_on_bit_zero: assert property (
		@(posedge clock2) disable iff (reset)
		frame |-> (bit_index == '0) ##8 frame
	);

endmodule

`default_nettype wire

//--- verilog/revo_encoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module revo_encoder_top (
	input wire logic clock2,
	input wire logic reset,
	input wire logic revo_in,
	output logic trg,
	output logic data,
	output logic frame
);
	import revo_pkg::*;

	history_t history;
	bit_index_t bit_index;
	logic eval_tick;

	// --------------------------------------------------
	// input side
	// --------------------------------------------------
	revo_input_sync input_sync (
		.clock2(clock2),
		.reset(reset),
		.revo_in(revo_in),
		.history(history)
	);

	// bit position and evaluation pace
	phase_timer timer (
		.clock2(clock2),
		.reset(reset),
		.bit_index(bit_index),
		.eval_tick(eval_tick)
	);

	// --------------------------------------------------
	// trigger decision
	// --------------------------------------------------
	revo_trigger_fsm trigger_fsm (
		.clock2(clock2),
		.reset(reset),
		.history(history),
		.eval_tick(eval_tick),
		.trg(trg)
	);

	// --------------------------------------------------
	// line output
	// --------------------------------------------------
	revo_word_serializer serializer (
		.clock2(clock2),
		.reset(reset),
		.bit_index(bit_index),
		.trg(trg),
		.data(data),
		.frame(frame)
	);

endmodule

`default_nettype wire

//--- dv/revo_encoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module revo_encoder_tb;
	import revo_pkg::*;

	localparam int num_tests = 8;
	localparam int reset_cycles = 4;
	localparam int lead_in = 40;
	localparam int drain = 24;
	localparam int min_gap = 40;
	localparam int max_gap = 55;
	// trg must rise this many cycles after the trailing edge at the latest
	localparam int trg_deadline = 16;
	localparam int eval_period = 4;
	localparam logic [31:0] rng_seed = 32'he7aa_a42e;

	typedef struct packed {
		logic [4:0] length;
		logic accept;
	} pulse_entry_t;

	logic clock2;
	logic reset;
	logic revo_in;
	logic trg;
	logic data;
	logic frame;

	pulse_entry_t pulse_table [num_tests];
	string test_names [num_tests];
	string current_test = "reset idle";

	logic [31:0] rng_state;
	int timeout_limit = 0;
	int cycle_count = 0;

	// reference model state
	logic [history_width+2:0] revo_samples;
	history_t model_history;
	window_t model_upper;
	window_t model_lower;
	logic rule_now;
	int rule_run;
	logic model_accept;

	// output monitor state
	logic frame_seen;
	int frame_age;
	logic last_trg;
	line_word_t asm_word;
	line_word_t asm_expected;
	int asm_bits;
	int words_checked = 0;

	revo_encoder_top DUT (
		.clock2(clock2),
		.reset(reset),
		.revo_in(revo_in),
		.trg(trg),
		.data(data),
		.frame(frame)
	);

	initial begin
		clock2 = 1'b0;
		forever #2 clock2 = ~clock2;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] value);
		logic [31:0] x;
		x = value;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			fail_run($sformatf("[ERROR] %s: expected %b, actual %b", name, expected, actual));
		end
	endtask

	task automatic compare_word(input string name, input line_word_t expected,
			input line_word_t actual);
		if (actual !== expected) begin
			fail_run($sformatf("[ERROR] %s: expected %b, actual %b", name, expected, actual));
		end
	endtask

	task automatic set_entry(input int index, input int length, input logic accept,
			input string name);
		pulse_table[index].length = length[4:0];
		pulse_table[index].accept = accept;
		test_names[index] = name;
	endtask

	// short pulses pass, anything reaching the older half is dropped
	task automatic load_table();
		set_entry(0, 1, 1'b1, "pulse_1_accept");
		set_entry(1, 2, 1'b1, "pulse_2_accept");
		set_entry(2, 3, 1'b1, "pulse_3_accept");
		set_entry(3, 4, 1'b1, "pulse_4_accept");
		set_entry(4, 8, 1'b0, "pulse_8_reject");
		set_entry(5, 9, 1'b0, "pulse_9_reject");
		set_entry(6, 12, 1'b0, "pulse_12_reject");
		set_entry(7, 15, 1'b0, "pulse_15_reject");
	endtask

	function automatic int run_length_limit();
		int total;
		total = reset_cycles + lead_in + drain + 100;
		for (int i = 0; i < num_tests; i++) begin
			total = total + pulse_table[i].length + max_gap;
		end
		return total;
	endfunction

	// one pulse followed by an idle gap, trg watched on every falling edge
	task automatic run_pulse(input int length, input int gap, output logic trg_in_pulse,
			output int first_high);
		trg_in_pulse = 1'b0;
		first_high = -1;
		for (int k = 0; k < length; k++) begin
			@(posedge clock2);
			if (k == 0) begin
				model_accept = 1'b0;
			end
			revo_in <= 1'b1;
			@(negedge clock2);
			if (trg !== 1'b0) begin
				trg_in_pulse = 1'b1;
			end
		end
		@(posedge clock2);
		revo_in <= 1'b0;
		for (int k = 0; k < gap; k++) begin
			@(negedge clock2);
			if (trg === 1'b1 && first_high < 0) begin
				first_high = k;
			end
		end
	endtask

	// --------------------------------------------------
	// reference model and output monitor
	// --------------------------------------------------
	always @(negedge clock2) begin
		if (reset) begin
			revo_samples = '0;
			rule_run = 0;
			frame_seen = 1'b0;
			frame_age = 0;
			last_trg = 1'b0;
			asm_bits = 0;
		end else begin
			// dut history lags revo_in by three samples
			revo_samples = {revo_samples[history_width+1:0], revo_in};
			model_history = revo_samples[history_width+2:3];
			model_upper = model_history[history_width-1:max_duration];
			model_lower = model_history[max_duration-1:0];
			rule_now = (model_upper == '0) && (model_lower != '0) && !model_history[0];
			rule_run = rule_now ? rule_run + 1 : 0;
			// a rule held for a whole round is seen by one capture
			if (rule_run >= eval_period) begin
				model_accept = 1'b1;
			end

			if (frame === 1'b1) begin
				if (frame_seen && frame_age + 1 != word_width) begin
					fail_run($sformatf("[ERROR] %s frame period: expected %0d, actual %0d",
						current_test, word_width, frame_age + 1));
				end
				frame_seen = 1'b1;
				frame_age = 0;
			end else if (frame_seen) begin
				frame_age = frame_age + 1;
				if (frame_age >= word_width) begin
					fail_run($sformatf("no frame strobe for %0d cycles", frame_age));
				end
			end

			// trg may only move at the start of a half word
			if (frame_seen && trg !== last_trg && (frame_age % eval_period) != 0) begin
				fail_run($sformatf("trg changed %0d cycles after a frame strobe", frame_age));
			end
			last_trg = trg;

			// rebuild the serial word, msb first
			if (frame === 1'b1) begin
				asm_word = {{(word_width-1){1'b0}}, data};
				asm_bits = 1;
				asm_expected = (trg === 1'b1) ? word_trg : word_null;
			end else if (asm_bits > 0 && asm_bits < word_width) begin
				asm_word = {asm_word[word_width-2:0], data};
				asm_bits = asm_bits + 1;
				if (asm_bits == word_width) begin
					compare_word({current_test, " word"}, asm_expected, asm_word);
					words_checked = words_checked + 1;
				end
			end
		end
	end

	always @(posedge clock2) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			fail_run($sformatf("timeout: run still going after %0d cycles", cycle_count));
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		int gap;
		int first_high;
		logic trg_in_pulse;
		logic trg_on_time;
		revo_in = 1'b0;
		reset = 1'b1;
		model_accept = 1'b0;
		rng_state = rng_seed;
		load_table();
		timeout_limit = run_length_limit();

		repeat (reset_cycles) @(posedge clock2);
		reset <= 1'b0;

		// nothing seen yet, so only null words go out
		for (int k = 0; k < lead_in; k++) begin
			@(negedge clock2);
			compare_bit("reset idle trg", 1'b0, trg);
		end

		for (int t = 0; t < num_tests; t++) begin
			current_test = test_names[t];
			rng_state = xorshift32(rng_state);
			gap = min_gap + (rng_state % (max_gap - min_gap + 1));
			run_pulse(pulse_table[t].length, gap, trg_in_pulse, first_high);

			compare_bit({current_test, " model"}, pulse_table[t].accept, model_accept);
			compare_bit({current_test, " trg during pulse"}, 1'b0, trg_in_pulse);
			trg_on_time = (first_high >= 0) && (first_high <= trg_deadline);
			compare_bit({current_test, " trg"}, model_accept, trg_on_time);
			if (!pulse_table[t].accept) begin
				compare_bit({current_test, " trg in gap"}, 1'b0, first_high >= 0);
			end
		end

		current_test = "drain";
		repeat (drain) @(negedge clock2);

		if (words_checked == 0) begin
			fail_run("no complete line word was seen");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- revo_encoder_top.f
verilog/revo_pkg.sv
verilog/revo_input_sync.sv
verilog/phase_timer.sv
verilog/revo_trigger_fsm.sv
verilog/revo_word_serializer.sv
verilog/revo_encoder_top.sv
dv/revo_encoder_tb.sv

//--- Bender.yml
package:
  name: revo_encoder

sources:
  # package first, the rtl modules import it
  - verilog/revo_pkg.sv
  - verilog/revo_input_sync.sv
  - verilog/phase_timer.sv
  - verilog/revo_trigger_fsm.sv
  - verilog/revo_word_serializer.sv
  - verilog/revo_encoder_top.sv

  - target: test
    files:
      - dv/revo_encoder_tb.sv
